// ==== logic/uart_pkg.sv ====
// UART APB shared types
package uart_pkg;

    localparam int APB_ADDR_W = 4;               // Byte address, two registers
    localparam int APB_DATA_W = 32;

    typedef struct packed {
        logic                  psel;
        logic                  penable;
        logic                  pwrite;
        logic [APB_ADDR_W-1:0] paddr;
        logic [APB_DATA_W-1:0] pwdata;
    } apb_req_t;

    typedef struct packed {
        logic [APB_DATA_W-1:0] prdata;
        logic                  pready;           // Tied high, zero wait
        logic                  pslverr;
    } apb_rsp_t;

    // Low bits of STATUS, rx_overrun is bit 0
    typedef struct packed {
        logic tx_full;
        logic tx_empty;
        logic rx_full;
        logic rx_empty;
        logic rx_overrun;                        // Sticky, cleared by STATUS read
    } uart_status_t;

    typedef enum logic [APB_ADDR_W-1:0] {
        ADDR_DATA   = 4'h0,                      // Write pushes tx, read pops rx
        ADDR_STATUS = 4'h4                       // Read only
    } reg_addr_e;

    // Serial frame phases, shared by rx and tx
    typedef enum logic [1:0] {
        IDLE,
        START,
        DATA,
        STOP
    } frame_state_e;

endpackage

// ==== logic/baud_tick_gen.sv ====
// Baud oversampling tick
`timescale 1ns/1ns
module baud_tick_gen #(
    parameter int DVSR = 163                     // Clocks per tick
) (
    input  logic i_clk,
    input  logic i_rst,
    output logic o_tick
);

    localparam int CW = (DVSR > 1) ? $clog2(DVSR) : 1;

    logic [CW-1:0] cnt;                          // 0 .. DVSR-1

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            cnt <= '0;
        end else if (cnt == CW'(DVSR - 1)) begin
            cnt <= '0;                           // Wrap
        end else begin
            cnt <= cnt + 1'b1;
        end
    end

    assign o_tick = (cnt == CW'(DVSR - 1));      // One cycle per period

endmodule

// ==== logic/uart_rx.sv ====
// Oversampling UART receiver
`timescale 1ns/1ns
module uart_rx #(
    parameter int DBIT    = 8,                   // Data bits
    parameter int SB_TICK = 16                   // Ticks in stop bit
) (
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic            i_rx,
    input  logic            i_tick,
    output logic            o_done,
    output logic [DBIT-1:0] o_data
);

    localparam int SW = (SB_TICK > 16) ? $clog2(SB_TICK) : 4;
    localparam int NW = $clog2(DBIT + 1);

    uart_pkg::frame_state_e state;
    logic [SW-1:0]          s_cnt;               // Ticks within bit
    logic [NW-1:0]          n_cnt;               // Bits received
    logic [DBIT-1:0]        shreg;
    logic                   done_q;

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state  <= uart_pkg::IDLE;
            s_cnt  <= '0;
            n_cnt  <= '0;
            done_q <= 1'b0;
        end else begin
            done_q <= 1'b0;
            case (state)
                uart_pkg::IDLE: begin
                    if (!i_rx) begin             // Falling edge, maybe start bit
                        state <= uart_pkg::START;
                        s_cnt <= '0;
                    end
                end
                uart_pkg::START: begin
                    if (i_tick) begin
                        if (s_cnt == SW'(7)) begin
                            s_cnt <= '0;         // Now at start bit center
                            n_cnt <= '0;
                            state <= i_rx ? uart_pkg::IDLE : uart_pkg::DATA;  // Glitch reject
                        end else begin
                            s_cnt <= s_cnt + 1'b1;
                        end
                    end
                end
                uart_pkg::DATA: begin
                    if (i_tick) begin
                        if (s_cnt == SW'(15)) begin
                            s_cnt <= '0;
                            if (n_cnt == NW'(DBIT - 1)) begin
                                state <= uart_pkg::STOP;
                            end else begin
                                n_cnt <= n_cnt + 1'b1;
                            end
                        end else begin
                            s_cnt <= s_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    if (i_tick) begin
                        if (s_cnt == SW'(SB_TICK - 1)) begin
                            state  <= uart_pkg::IDLE;
                            done_q <= 1'b1;      // Byte complete
                        end else begin
                            s_cnt <= s_cnt + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    // Sample at bit center, LSB arrives first
    always_ff @(posedge i_clk) begin
        if (state == uart_pkg::DATA && i_tick && s_cnt == SW'(15)) begin
            shreg <= {i_rx, shreg[DBIT-1:1]};
        end
    end

    assign o_done = done_q;
    assign o_data = shreg;

    a_done_pulse: assert property (@(posedge i_clk) disable iff (i_rst) o_done |=> !o_done);

endmodule

// ==== logic/uart_tx.sv ====
// UART serial transmitter
`timescale 1ns/1ns
module uart_tx #(
    parameter int DBIT    = 8,                   // Data bits
    parameter int SB_TICK = 16                   // Ticks in stop bit
) (
    input  logic            i_clk,
    input  logic            i_rst,
    input  logic            i_start,
    input  logic [DBIT-1:0] i_data,
    input  logic            i_tick,
    output logic            o_done,
    output logic            o_tx
);

    localparam int SW = (SB_TICK > 16) ? $clog2(SB_TICK) : 4;
    localparam int NW = $clog2(DBIT + 1);

    uart_pkg::frame_state_e state;
    logic [SW-1:0]          s_cnt;               // Ticks within bit
    logic [NW-1:0]          n_cnt;               // Bits sent
    logic [DBIT-1:0]        shreg;
    logic                   tx_q;                // Registered line, glitch free

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            state <= uart_pkg::IDLE;
            s_cnt <= '0;
            n_cnt <= '0;
            tx_q  <= 1'b1;                       // Line idles high
        end else begin
            case (state)
                uart_pkg::IDLE: begin
                    tx_q <= 1'b1;
                    if (i_start) begin           // FIFO has a word
                        state <= uart_pkg::START;
                        s_cnt <= '0;
                    end
                end
                uart_pkg::START: begin
                    tx_q <= 1'b0;
                    if (i_tick) begin
                        if (s_cnt == SW'(15)) begin
                            state <= uart_pkg::DATA;
                            s_cnt <= '0;
                            n_cnt <= '0;
                        end else begin
                            s_cnt <= s_cnt + 1'b1;
                        end
                    end
                end
                uart_pkg::DATA: begin
                    tx_q <= shreg[0];            // LSB first
                    if (i_tick) begin
                        if (s_cnt == SW'(15)) begin
                            s_cnt <= '0;
                            if (n_cnt == NW'(DBIT - 1)) begin
                                state <= uart_pkg::STOP;
                            end else begin
                                n_cnt <= n_cnt + 1'b1;
                            end
                        end else begin
                            s_cnt <= s_cnt + 1'b1;
                        end
                    end
                end
                default: begin
                    tx_q <= 1'b1;
                    if (i_tick) begin
                        if (s_cnt == SW'(SB_TICK - 1)) begin
                            state <= uart_pkg::IDLE;
                        end else begin
                            s_cnt <= s_cnt + 1'b1;
                        end
                    end
                end
            endcase
        end
    end

    always_ff @(posedge i_clk) begin
        if (state == uart_pkg::IDLE && i_start) begin
            shreg <= i_data;                     // Latch FIFO head
        end else if (state == uart_pkg::DATA && i_tick && s_cnt == SW'(15)) begin
            shreg <= shreg >> 1;
        end
    end

    // Same edge as return to IDLE, so the next head is ready in IDLE
    assign o_done = (state == uart_pkg::STOP) && i_tick && (s_cnt == SW'(SB_TICK - 1));
    assign o_tx   = tx_q;

    a_idle_high: assert property (@(posedge i_clk) disable iff (i_rst)
        state == uart_pkg::IDLE |-> o_tx);

endmodule

// ==== logic/sync_fifo.sv ====
// Synchronous FIFO
`timescale 1ns/1ns
module sync_fifo #(
    parameter int WIDTH   = 8,
    parameter int DEPTH_W = 2                    // 2^DEPTH_W entries
) (
    input  logic             i_clk,
    input  logic             i_rst,
    input  logic             i_push,
    input  logic             i_pop,
    input  logic [WIDTH-1:0] i_data,
    output logic [WIDTH-1:0] o_data,
    output logic             o_full,
    output logic             o_empty
);

    localparam int DEPTH = 2 ** DEPTH_W;

    logic [WIDTH-1:0]   mem [DEPTH];
    logic [DEPTH_W-1:0] wr_ptr;
    logic [DEPTH_W-1:0] rd_ptr;
    logic [DEPTH_W:0]   count;                   // One extra bit for full
    logic               do_push;
    logic               do_pop;

    assign do_push = i_push && !o_full;          // Drop push when full
    assign do_pop  = i_pop && !o_empty;          // Drop pop when empty

    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push) wr_ptr <= wr_ptr + 1'b1;
            if (do_pop)  rd_ptr <= rd_ptr + 1'b1;
            count <= count + {{DEPTH_W{1'b0}}, do_push} - {{DEPTH_W{1'b0}}, do_pop};
        end
    end

    always_ff @(posedge i_clk) begin
        if (do_push) mem[wr_ptr] <= i_data;
    end

    assign o_data  = mem[rd_ptr];                // Show-ahead head
    assign o_full  = (count == (DEPTH_W + 1)'(DEPTH));
    assign o_empty = (count == '0);

    a_count_max: assert property (@(posedge i_clk) disable iff (i_rst)
        count <= (DEPTH_W + 1)'(DEPTH));

endmodule

// ==== logic/apb_uart_regs.sv ====
// APB register decoder for UART
`timescale 1ns/1ns
module apb_uart_regs #(
    parameter int DBIT = 8
) (
    input  logic                  i_clk,
    input  logic                  i_rst,
    input  uart_pkg::apb_req_t    i_req,
    input  logic [DBIT-1:0]       i_rx_data,     // rx FIFO head
    input  logic                  i_rx_done,     // Byte from receiver
    input  logic                  i_tx_full,
    input  logic                  i_tx_empty,
    input  logic                  i_rx_full,
    input  logic                  i_rx_empty,
    output uart_pkg::apb_rsp_t    o_rsp,
    output logic                  o_tx_push,
    output logic [DBIT-1:0]       o_tx_data,
    output logic                  o_rx_pop
);

    logic                   access;              // Access phase, completes now
    logic                   is_data;
    logic                   is_status;
    logic                   rd_status;
    logic                   overrun;
    uart_pkg::uart_status_t status;

    assign access    = i_req.psel && i_req.penable;
    assign is_data   = (i_req.paddr == uart_pkg::ADDR_DATA);
    assign is_status = (i_req.paddr == uart_pkg::ADDR_STATUS);
    assign rd_status = access && !i_req.pwrite && is_status;

    assign o_tx_push = access && i_req.pwrite && is_data && !i_tx_full;
    assign o_tx_data = i_req.pwdata[DBIT-1:0];
    assign o_rx_pop  = access && !i_req.pwrite && is_data && !i_rx_empty;

    assign status = '{tx_full:    i_tx_full,
                      tx_empty:   i_tx_empty,
                      rx_full:    i_rx_full,
                      rx_empty:   i_rx_empty,
                      rx_overrun: overrun};

    always_comb begin
        o_rsp         = '0;
        o_rsp.pready  = 1'b1;                    // Zero wait states
        if (access) begin
            if (is_data) begin
                o_rsp.pslverr = i_req.pwrite ? i_tx_full : i_rx_empty;
                if (!i_req.pwrite && !i_rx_empty) begin
                    o_rsp.prdata[DBIT-1:0] = i_rx_data;  // Zero extended
                end
            end else if (is_status) begin
                o_rsp.pslverr = i_req.pwrite;    // Read only
                if (!i_req.pwrite) begin
                    o_rsp.prdata[$bits(uart_pkg::uart_status_t)-1:0] = status;
                end
            end else begin
                o_rsp.pslverr = 1'b1;            // Unmapped
            end
        end
    end

    // Sticky overrun, a new drop wins over the clearing read
    always_ff @(posedge i_clk) begin
        if (i_rst) begin
            overrun <= 1'b0;
        end else if (i_rx_done && i_rx_full) begin
            overrun <= 1'b1;
        end else if (rd_status) begin
            overrun <= 1'b0;
        end
    end

    a_pready: assert property (@(posedge i_clk) disable iff (i_rst) o_rsp.pready);
    a_no_push_full: assert property (@(posedge i_clk) disable iff (i_rst)
        !(o_tx_push && i_tx_full));

endmodule

// ==== logic/apb_uart.sv ====
// UART with APB slave interface
`timescale 1ns/1ns
module apb_uart #(
    parameter int DBIT    = 8,                   // Data bits, at most 32
    parameter int SB_TICK = 16,                  // 16/24/32 for 1/1.5/2 stop bits
    parameter int DVSR    = 163,                 // Clock / (baud * 16)
    parameter int FIFO_W  = 2                    // 2^FIFO_W words per FIFO
) (
    input  logic               i_clk,
    input  logic               i_rst,
    input  uart_pkg::apb_req_t i_apb,
    output uart_pkg::apb_rsp_t o_apb,
    input  logic               i_rx,
    output logic               o_tx
);

    logic            tick;
    logic            rx_done;                    // Receiver byte strobe
    logic [DBIT-1:0] rx_data;
    logic            rx_pop;
    logic [DBIT-1:0] rx_head;
    logic            rx_full;
    logic            rx_empty;
    logic            tx_done;                    // Frame sent, pops tx FIFO
    logic            tx_push;
    logic [DBIT-1:0] tx_wdata;
    logic [DBIT-1:0] tx_head;
    logic            tx_full;
    logic            tx_empty;

    baud_tick_gen #(.DVSR(DVSR)) baud_tick_gen_i (
        .i_clk(i_clk), .i_rst(i_rst), .o_tick(tick));

    uart_rx #(.DBIT(DBIT), .SB_TICK(SB_TICK)) uart_rx_i (
        .i_clk(i_clk), .i_rst(i_rst), .i_rx(i_rx), .i_tick(tick),
        .o_done(rx_done), .o_data(rx_data));

    sync_fifo #(.WIDTH(DBIT), .DEPTH_W(FIFO_W)) rx_fifo_i (
        .i_clk(i_clk), .i_rst(i_rst), .i_push(rx_done), .i_pop(rx_pop),
        .i_data(rx_data), .o_data(rx_head), .o_full(rx_full), .o_empty(rx_empty));

    sync_fifo #(.WIDTH(DBIT), .DEPTH_W(FIFO_W)) tx_fifo_i (
        .i_clk(i_clk), .i_rst(i_rst), .i_push(tx_push), .i_pop(tx_done),
        .i_data(tx_wdata), .o_data(tx_head), .o_full(tx_full), .o_empty(tx_empty));

    uart_tx #(.DBIT(DBIT), .SB_TICK(SB_TICK)) uart_tx_i (
        .i_clk(i_clk), .i_rst(i_rst), .i_start(!tx_empty), .i_data(tx_head),
        .i_tick(tick), .o_done(tx_done), .o_tx(o_tx));

    apb_uart_regs #(.DBIT(DBIT)) apb_uart_regs_i (
        .i_clk      (i_clk),
        .i_rst      (i_rst),
        .i_req      (i_apb),
        .i_rx_data  (rx_head),
        .i_rx_done  (rx_done),                   // Overrun seen with rx_full
        .i_tx_full  (tx_full),
        .i_tx_empty (tx_empty),
        .i_rx_full  (rx_full),
        .i_rx_empty (rx_empty),
        .o_rsp      (o_apb),
        .o_tx_push  (tx_push),
        .o_tx_data  (tx_wdata),
        .o_rx_pop   (rx_pop)
    );

endmodule

// ==== verification/apb_uart_tb.sv ====
// APB UART loopback testbench
`timescale 1ns/1ns
module apb_uart_tb;

    localparam int DBIT   = 8;
    localparam int DVSR   = 4;                       // Fast baud for simulation
    localparam int FIFO_W = 2;
    localparam int DEPTH  = 2 ** FIFO_W;
    localparam int FRAME  = (DBIT + 2) * 16 * DVSR;  // Clocks per serial frame
    localparam int LIMIT  = 12 * FRAME + 1000;

    // Status bits from tx_full down to rx_overrun
    localparam uart_pkg::uart_status_t ALL      = 5'b11111;
    localparam uart_pkg::uart_status_t IDLE_ST  = 5'b01010;  // Both FIFOs empty
    localparam uart_pkg::uart_status_t TX_FULL  = 5'b10000;
    localparam uart_pkg::uart_status_t TX_EMPTY = 5'b01000;
    localparam uart_pkg::uart_status_t RX_FULL  = 5'b00100;
    localparam uart_pkg::uart_status_t OVERRUN  = 5'b00001;

    logic               clk;
    logic               rst;
    uart_pkg::apb_req_t req;
    uart_pkg::apb_rsp_t rsp;
    logic               serial;                      // o_tx looped back to i_rx
    logic [31:0]        lfsr;
    int                 cycles = 0;

    apb_uart #(.DVSR(DVSR)) apb_uart_i (
        .i_clk(clk), .i_rst(rst), .i_apb(req), .o_apb(rsp), .i_rx(serial), .o_tx(serial));

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles == LIMIT) begin
            $display("Timeout after %0d cycles, DUT never reached the awaited state", LIMIT);
            $display("Test failed");
            $fatal(1, "Simulation stopped on timeout");
        end
    end

    // Taps 32, 22, 2, 1
    function automatic logic [31:0] lfsr_next(input logic [31:0] s);
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic rand_data(output logic [DBIT-1:0] d);
        for (int i = 0; i < DBIT; i++) begin
            lfsr = lfsr_next(lfsr);                  // One step per bit
            d[i] = lfsr[0];
        end
    endtask

    task automatic report_mismatch(input string msg);
        $display("ERR %0t: %s", $time, msg);
        $display("Test failed");
        $fatal(1, "Stopped at first mismatch");
    endtask

    task automatic check_data(input logic [DBIT-1:0] got, exp, input string msg);
        if (got !== exp) report_mismatch($sformatf("%s: got %h expected %h", msg, got, exp));
    endtask

    task automatic check_status(input uart_pkg::uart_status_t got, exp, care, input string msg);
        if ((got & care) !== (exp & care))
            report_mismatch($sformatf("%s: got %b expected %b mask %b", msg, got, exp, care));
    endtask

    task automatic check_err(input logic got, exp, input string msg);
        if (got !== exp) report_mismatch($sformatf("%s: pslverr %b expected %b", msg, got, exp));
    endtask

    task automatic check_ready(input logic got, input string msg);
        if (got !== 1'b1) report_mismatch($sformatf("%s: pready %b expected 1", msg, got));
    endtask

    task automatic check_line(input logic got, exp, input string msg);
        if (got !== exp) report_mismatch($sformatf("%s: line %b expected %b", msg, got, exp));
    endtask

    // Setup then access phase with response sampled mid access cycle
    task automatic apb_access(input logic wr, input logic [uart_pkg::APB_ADDR_W-1:0] addr,
                              input logic [uart_pkg::APB_DATA_W-1:0] wdata,
                              output uart_pkg::apb_rsp_t r);
        @(negedge clk);
        req = '{psel: 1'b1, penable: 1'b0, pwrite: wr, paddr: addr, pwdata: wdata};
        @(negedge clk);
        req.penable = 1'b1;                          // Completes on next rising edge
        #1;
        r = rsp;
        check_ready(r.pready, "APB access phase");   // Zero wait slave
        @(negedge clk);
        req = '0;
    endtask

    task automatic apb_write(input logic [uart_pkg::APB_ADDR_W-1:0] addr,
                             input logic [uart_pkg::APB_DATA_W-1:0] wdata,
                             output uart_pkg::apb_rsp_t r);
        apb_access(1'b1, addr, wdata, r);
    endtask

    task automatic apb_read(input logic [uart_pkg::APB_ADDR_W-1:0] addr,
                            output uart_pkg::apb_rsp_t r);
        apb_access(1'b0, addr, '0, r);
    endtask

    task automatic read_status(output uart_pkg::uart_status_t st);
        uart_pkg::apb_rsp_t r;
        apb_read(uart_pkg::ADDR_STATUS, r);
        check_err(r.pslverr, 1'b0, "STATUS read");
        st = r.prdata[$bits(uart_pkg::uart_status_t)-1:0];
    endtask

    // Poll until the masked bits match
    task automatic wait_status(input uart_pkg::uart_status_t care, want,
                               output uart_pkg::uart_status_t st);
        do begin
            read_status(st);
        end while ((st & care) != (want & care));
    endtask

    task automatic send_byte(input logic [DBIT-1:0] b);
        uart_pkg::apb_rsp_t r;
        apb_write(uart_pkg::ADDR_DATA, 32'(b), r);
        check_err(r.pslverr, 1'b0, "DATA write");
    endtask

    task automatic read_rx_bytes(input logic [DBIT-1:0] exp [DEPTH]);
        uart_pkg::apb_rsp_t     r;
        uart_pkg::uart_status_t st;
        for (int i = 0; i < DEPTH; i++) begin
            apb_read(uart_pkg::ADDR_DATA, r);
            check_err(r.pslverr, 1'b0, "rx DATA read");
            check_data(r.prdata[DBIT-1:0], exp[i], $sformatf("rx byte %0d", i));
        end
        read_status(st);
        check_status(st, IDLE_ST, ALL, "status after draining rx FIFO");
    endtask

    task automatic reset_defaults();
        uart_pkg::uart_status_t st;
        read_status(st);
        check_status(st, IDLE_ST, ALL, "status after reset");
        check_line(serial, 1'b1, "o_tx after reset");
    endtask

    task automatic single_loopback();
        logic [DBIT-1:0]        b;
        uart_pkg::apb_rsp_t     r;
        uart_pkg::uart_status_t st;
        rand_data(b);
        send_byte(b);
        wait_status(5'b00010, '0, st);               // rx_empty falls
        apb_read(uart_pkg::ADDR_DATA, r);
        check_err(r.pslverr, 1'b0, "single DATA read");
        check_data(r.prdata[DBIT-1:0], b, "looped back byte");
        wait_status(TX_EMPTY, TX_EMPTY, st);         // Stop bit done
        check_status(st, IDLE_ST, ALL, "status after single byte");
    endtask

    task automatic tx_backpressure();
        logic [DBIT-1:0]        sent [DEPTH];
        uart_pkg::apb_rsp_t     r;
        uart_pkg::uart_status_t st;
        for (int i = 0; i < DEPTH; i++) begin
            rand_data(sent[i]);
            send_byte(sent[i]);
        end
        read_status(st);
        check_status(st, TX_FULL, TX_FULL, "tx FIFO full after burst");
        apb_write(uart_pkg::ADDR_DATA, 32'h5a, r);   // Dropped
        check_err(r.pslverr, 1'b1, "DATA write with tx FIFO full");
        wait_status(RX_FULL | TX_EMPTY, RX_FULL | TX_EMPTY, st);
        check_status(st, RX_FULL | TX_EMPTY, ALL, "status after burst");
        read_rx_bytes(sent);
    endtask

    task automatic rx_overrun();
        logic [DBIT-1:0]        sent [DEPTH];
        logic [DBIT-1:0]        lost;
        uart_pkg::uart_status_t st;
        for (int i = 0; i < DEPTH; i++) begin
            rand_data(sent[i]);
            send_byte(sent[i]);
            wait_status(TX_EMPTY, TX_EMPTY, st);     // One frame at a time
        end
        rand_data(lost);
        send_byte(lost);
        wait_status(OVERRUN, OVERRUN, st);
        check_status(st, RX_FULL | OVERRUN, RX_FULL | OVERRUN, "overrun flagged");
        read_status(st);
        check_status(st, '0, OVERRUN, "overrun cleared by STATUS read");
        wait_status(TX_EMPTY, TX_EMPTY, st);
        check_status(st, RX_FULL | TX_EMPTY, ALL, "status before drain");
        read_rx_bytes(sent);                         // Last byte gone
    endtask

    task automatic illegal_accesses();
        uart_pkg::apb_rsp_t     r;
        uart_pkg::uart_status_t st;
        apb_read(uart_pkg::ADDR_DATA, r);
        check_err(r.pslverr, 1'b1, "DATA read with rx FIFO empty");
        check_data(r.prdata[DBIT-1:0], '0, "empty DATA read value");
        apb_write(uart_pkg::ADDR_STATUS, 32'h1f, r);
        check_err(r.pslverr, 1'b1, "STATUS write");
        apb_read(4'h8, r);
        check_err(r.pslverr, 1'b1, "unmapped read");
        apb_write(4'h8, 32'h33, r);
        check_err(r.pslverr, 1'b1, "unmapped write");
        read_status(st);
        check_status(st, IDLE_ST, ALL, "status after illegal accesses");
    endtask

    initial begin
        clk  = 1'b0;
        rst  = 1'b1;
        req  = '0;
        lfsr = 32'h102e58d4;
        repeat (3) @(posedge clk);
        @(negedge clk);
        rst = 1'b0;
        reset_defaults();
        single_loopback();
        tx_backpressure();
        rx_overrun();
        illegal_accesses();
        $display("Test completed successfully");
        $finish;
    end

endmodule

// ==== apb_uart.f ====
logic/uart_pkg.sv
logic/baud_tick_gen.sv
logic/uart_rx.sv
logic/uart_tx.sv
logic/sync_fifo.sv
logic/apb_uart_regs.sv
logic/apb_uart.sv
verification/apb_uart_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the APB UART testbench with Verilator
verilator --binary --timing --assert -Wno-fatal --top-module apb_uart_tb -f apb_uart.f \
    -o apb_uart_sim > build.log 2>&1 || { cat build.log; exit 1; }
./obj_dir/apb_uart_sim > sim.log 2>&1
cat sim.log
grep -q "Test completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
